// ==== logic/corr_cfg_pkg.sv ====
package corr_cfg_pkg;

   // ------------------------------------------------------------------------
   // array geometry and accumulator sizing
   // ------------------------------------------------------------------------
   localparam int ANT_COUNT  = 24;   // antennas, one re and one im sign bit each
   localparam int PAIR_COUNT = 12;   // pairs visited per sweep
   localparam int PAIR_W     = 4;    // pair index width
   localparam int ANT_W      = 5;    // antenna index width
   localparam int ACC_W      = 8;    // small on purpose, wraps after 256 hits

   localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(PAIR_COUNT - 1);

   // one table entry, antenna a against antenna b
   typedef struct packed {
      logic [ANT_W-1:0] a;
      logic [ANT_W-1:0] b;
   } ant_pair_t;

   // element i is pair i of the sweep
   localparam ant_pair_t PAIR_TABLE [PAIR_COUNT] = '{
      '{a: 5'd0,  b: 5'd1},
      '{a: 5'd0,  b: 5'd2},
      '{a: 5'd0,  b: 5'd3},
      '{a: 5'd1,  b: 5'd2},
      '{a: 5'd1,  b: 5'd3},
      '{a: 5'd2,  b: 5'd3},
      '{a: 5'd4,  b: 5'd5},
      '{a: 5'd6,  b: 5'd7},
      '{a: 5'd8,  b: 5'd9},
      '{a: 5'd10, b: 5'd11},
      '{a: 5'd12, b: 5'd23},
      '{a: 5'd16, b: 5'd20}
   };

   // ------------------------------------------------------------------------
   // data items moving through the pipeline
   // ------------------------------------------------------------------------
   typedef struct packed {
      logic [ANT_COUNT-1:0] re;   // real sign bits, bit k is antenna k
      logic [ANT_COUNT-1:0] im;   // imaginary sign bits
   } sample_t;

   typedef struct packed {
      logic [ACC_W-1:0] sin;
      logic [ACC_W-1:0] cos;
   } vis_t;

   typedef struct packed {
      logic [PAIR_W-1:0] pair;    // index into PAIR_TABLE
      logic              ar;      // real bit of antenna a
      logic              br;      // real bit of antenna b
      logic              bi;      // imaginary bit of antenna b
      logic              bank;    // visibility bank this sweep writes
      logic              first;   // first sweep into the bank, start from zero
   } pair_item_t;

   typedef struct packed {
      logic [PAIR_W-1:0] pair;
      logic              bank;
      vis_t              vis;     // running sums after this sample
   } mac_item_t;

endpackage

// ==== logic/corr_bus_pkg.sv ====
package corr_bus_pkg;

   // ------------------------------------------------------------------------
   // visibility read bus
   // ------------------------------------------------------------------------
   // address layout: [4:1] pair index, [0] selects sin (1) or cos (0)
   localparam int BUS_ADDR_W = 5;

   typedef enum logic {
      BUS_READ  = 1'b0,
      BUS_WRITE = 1'b1    // acknowledged, never stored
   } bus_op_e;

   typedef struct packed {
      bus_op_e                        op;
      logic [BUS_ADDR_W-1:0]          addr;
      logic [corr_cfg_pkg::ACC_W-1:0] wdata;   // ignored by the correlator
   } bus_req_t;

   typedef struct packed {
      logic [corr_cfg_pkg::ACC_W-1:0] rdata;
   } bus_rsp_t;

endpackage

// ==== logic/pair_select.sv ====
`timescale 1ns/1ps

module pair_select (
   input  logic                     clk_x,
   input  logic                     rst,
   input  corr_cfg_pkg::sample_t    sample_i,
   input  logic                     sample_valid_i,
   output logic                     sample_ready_o,
   input  logic                     swap_i,       // one-cycle bank swap request
   output corr_cfg_pkg::pair_item_t item_o,
   output logic                     item_valid_o
);

   typedef enum logic {
      IDLE,
      SWEEP
   } state_e;

   state_e                          state_q;
   corr_cfg_pkg::sample_t           sample_q;     // word being swept
   logic [corr_cfg_pkg::PAIR_W-1:0] pair_q;
   logic                            swap_pend_q;
   logic                            bank_q;       // bank of the sweep in progress
   logic                            first_q;
   logic                            last_pair;
   logic                            boundary;
   logic                            take;
   logic                            do_swap;
   corr_cfg_pkg::ant_pair_t         pair_sel;

   assign last_pair      = (state_q == SWEEP) && (pair_q == corr_cfg_pkg::LAST_PAIR);
   assign boundary       = (state_q == IDLE) || last_pair;   // next sweep may start
   assign sample_ready_o = boundary;
   assign take           = sample_valid_i && boundary;
   assign do_swap        = boundary && (swap_pend_q || swap_i);
   assign pair_sel       = corr_cfg_pkg::PAIR_TABLE[pair_q];

   // ------------------------------------------------------------------------
   // sweep sequencer and bank bookkeeping
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state_q     <= IDLE;
         pair_q      <= '0;
         swap_pend_q <= 1'b0;
         bank_q      <= 1'b0;
         first_q     <= 1'b1;        // accumulators hold junk after reset
      end else begin
         if (take) begin
            state_q <= SWEEP;          // back to back, no gap after pair 11
            pair_q  <= '0;
         end else if (last_pair) begin
            state_q <= IDLE;
            pair_q  <= '0;
         end else if (state_q == SWEEP) begin
            pair_q <= pair_q + 1'b1;
         end

         if (do_swap) begin
            swap_pend_q <= 1'b0;
            bank_q      <= ~bank_q;
            first_q     <= 1'b1;       // new bank counts from zero
         end else begin
            if (swap_i)
               swap_pend_q <= 1'b1;    // wait for the sweep to finish
            if (last_pair)
               first_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_x) begin
      if (take)
         sample_q <= sample_i;
   end

   // item register, the bank tag goes out every cycle so idle slots carry flips
   always_ff @(posedge clk_x) begin
      if (rst) begin
         item_o       <= '0;
         item_valid_o <= 1'b0;
      end else begin
         item_valid_o <= (state_q == SWEEP);
         item_o.pair  <= pair_q;
         item_o.ar    <= sample_q.re[pair_sel.a];
         item_o.br    <= sample_q.re[pair_sel.b];
         item_o.bi    <= sample_q.im[pair_sel.b];
         item_o.bank  <= bank_q;
         item_o.first <= first_q;
      end
   end

   // pair indices stay in the table
   assert property (@(posedge clk_x) disable iff (rst)
      item_valid_o |-> item_o.pair <= corr_cfg_pkg::LAST_PAIR);

endmodule

// ==== logic/cos_sin_mac.sv ====
`timescale 1ns/1ps

module cos_sin_mac (
   input  logic                     clk_x,
   input  logic                     rst,
   input  corr_cfg_pkg::pair_item_t item_i,
   input  logic                     item_valid_i,
   output corr_cfg_pkg::mac_item_t  mac_o,
   output logic                     mac_valid_o,
   output logic                     overflow_cos_o,   // sticky
   output logic                     overflow_sin_o    // sticky
);

   // ------------------------------------------------------------------------
   // accumulator memory, one vis_t per pair
   // ------------------------------------------------------------------------
   corr_cfg_pkg::vis_t       acc_mem [corr_cfg_pkg::PAIR_COUNT];

   corr_cfg_pkg::pair_item_t rd_item_q;   // item waiting on its memory read
   logic                     rd_valid_q;
   corr_cfg_pkg::vis_t       rd_acc_q;    // old sums, or zero on a first sweep
   logic                     cos_hit;
   logic                     sin_hit;
   corr_cfg_pkg::vis_t       sum;

   // cycle 1 -----------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         rd_item_q  <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         rd_item_q  <= item_i;         // bank tag moves on idle cycles too
         rd_valid_q <= item_valid_i;
      end
   end

   always_ff @(posedge clk_x) begin
      if (item_valid_i) begin
         if (item_i.first)
            rd_acc_q <= '0;            // clear on the new period
         else
            rd_acc_q <= acc_mem[item_i.pair];
      end
   end

   // cycle 2 -----------------------------------------------------------------
   // a one-bit sign product is just an xnor of the two bits
   assign cos_hit = rd_item_q.ar ~^ rd_item_q.br;
   assign sin_hit = rd_item_q.ar ~^ rd_item_q.bi;

   assign sum.cos = rd_acc_q.cos + cos_hit;   // wraps mod 2^ACC_W
   assign sum.sin = rd_acc_q.sin + sin_hit;

   always_ff @(posedge clk_x) begin
      if (rd_valid_q)
         acc_mem[rd_item_q.pair] <= sum;      // write-back
   end

   always_ff @(posedge clk_x) begin
      if (rst) begin
         mac_o       <= '0;
         mac_valid_o <= 1'b0;
      end else begin
         mac_valid_o <= rd_valid_q;
         mac_o.pair  <= rd_item_q.pair;
         mac_o.bank  <= rd_item_q.bank;
         mac_o.vis   <= sum;
      end
   end

   // overflow flags ----------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         overflow_cos_o <= 1'b0;
         overflow_sin_o <= 1'b0;
      end else if (rd_valid_q) begin
         if (cos_hit && (rd_acc_q.cos == '1))
            overflow_cos_o <= 1'b1;   // all ones plus one is a wrap
         if (sin_hit && (rd_acc_q.sin == '1))
            overflow_sin_o <= 1'b1;
      end
   end

   // the read of a new item never hits the entry written back this cycle,
   // needs PAIR_COUNT larger than the read to write-back distance
   assert property (@(posedge clk_x) disable iff (rst)
      item_valid_i && rd_valid_q |-> item_i.pair != rd_item_q.pair);

endmodule

// ==== logic/vis_bank.sv ====
`timescale 1ns/1ps

module vis_bank (
   input  logic                    clk_x,
   input  logic                    rst,
   input  corr_cfg_pkg::mac_item_t mac_i,
   input  logic                    mac_valid_i,
   input  corr_bus_pkg::bus_req_t  bus_req_i,
   input  logic                    bus_req_valid_i,
   output logic                    bus_req_ready_o,
   output corr_bus_pkg::bus_rsp_t  bus_rsp_o,
   output logic                    bus_rsp_valid_o,
   input  logic                    bus_rsp_ready_i
);

   // ------------------------------------------------------------------------
   // two-bank visibility memory
   // ------------------------------------------------------------------------
   corr_cfg_pkg::vis_t              vis_mem [2][corr_cfg_pkg::PAIR_COUNT];

   logic                            active_q;      // bank the pipeline now feeds
   logic [corr_cfg_pkg::PAIR_W-1:0] rd_pair;
   logic                            rd_in_range;
   logic                            req_take;
   corr_cfg_pkg::vis_t              rd_vis;
   logic [corr_cfg_pkg::ACC_W-1:0]  rd_word;

   always_ff @(posedge clk_x) begin
      if (mac_valid_i)
         vis_mem[mac_i.bank][mac_i.pair] <= mac_i.vis;
   end

   // follows the tag of the latest item, which also arrives on idle slots,
   // so a swap shows here right after the old sweep's final write
   always_ff @(posedge clk_x) begin
      if (rst)
         active_q <= 1'b0;
      else
         active_q <= mac_i.bank;
   end

   // ------------------------------------------------------------------------
   // bus read port, always from the inactive bank
   // ------------------------------------------------------------------------
   assign rd_pair     = bus_req_i.addr[corr_bus_pkg::BUS_ADDR_W-1:1];
   assign rd_in_range = rd_pair < corr_cfg_pkg::PAIR_COUNT;
   assign rd_vis      = vis_mem[~active_q][rd_pair];

   always_comb begin
      rd_word = '0;                  // writes and unused pairs read as zero
      if ((bus_req_i.op == corr_bus_pkg::BUS_READ) && rd_in_range) begin
         if (bus_req_i.addr[0])
            rd_word = rd_vis.sin;
         else
            rd_word = rd_vis.cos;
      end
   end

   // a held response blocks new requests
   assign bus_req_ready_o = !bus_rsp_valid_o || bus_rsp_ready_i;
   assign req_take        = bus_req_valid_i && bus_req_ready_o;

   always_ff @(posedge clk_x) begin
      if (rst)
         bus_rsp_valid_o <= 1'b0;
      else if (req_take)
         bus_rsp_valid_o <= 1'b1;    // one cycle after the request
      else if (bus_rsp_ready_i)
         bus_rsp_valid_o <= 1'b0;
   end

   always_ff @(posedge clk_x) begin
      if (req_take)
         bus_rsp_o.rdata <= rd_word;
   end

   // response holds still under back-pressure
   assert property (@(posedge clk_x) disable iff (rst)
      bus_rsp_valid_o && !bus_rsp_ready_i
      |=> bus_rsp_valid_o && $stable(bus_rsp_o));

endmodule

// ==== logic/correlator_top.sv ====
`timescale 1ns/1ps

module correlator_top (
   input  logic                   clk_x,
   input  logic                   rst,
   input  corr_cfg_pkg::sample_t  sample_i,
   input  logic                   sample_valid_i,
   output logic                   sample_ready_o,
   input  logic                   swap_i,
   input  corr_bus_pkg::bus_req_t bus_req_i,
   input  logic                   bus_req_valid_i,
   output logic                   bus_req_ready_o,
   output corr_bus_pkg::bus_rsp_t bus_rsp_o,
   output logic                   bus_rsp_valid_o,
   input  logic                   bus_rsp_ready_i,
   output logic                   overflow_cos_o,
   output logic                   overflow_sin_o
);

   corr_cfg_pkg::pair_item_t item;        // stage 1 to stage 2
   logic                     item_valid;
   corr_cfg_pkg::mac_item_t  mac;         // stage 2 to stage 3
   logic                     mac_valid;

   // ------------------------------------------------------------------------
   // three stage pipeline, no back-pressure between stages
   // ------------------------------------------------------------------------
   pair_select pair_select_i (
      .clk_x          (clk_x),
      .rst            (rst),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .sample_ready_o (sample_ready_o),
      .swap_i         (swap_i),
      .item_o         (item),
      .item_valid_o   (item_valid)
   );

   cos_sin_mac cos_sin_mac_i (
      .clk_x          (clk_x),
      .rst            (rst),
      .item_i         (item),
      .item_valid_i   (item_valid),
      .mac_o          (mac),
      .mac_valid_o    (mac_valid),
      .overflow_cos_o (overflow_cos_o),
      .overflow_sin_o (overflow_sin_o)
   );

   vis_bank vis_bank_i (
      .clk_x           (clk_x),
      .rst             (rst),
      .mac_i           (mac),
      .mac_valid_i     (mac_valid),
      .bus_req_i       (bus_req_i),
      .bus_req_valid_i (bus_req_valid_i),
      .bus_req_ready_o (bus_req_ready_o),
      .bus_rsp_o       (bus_rsp_o),
      .bus_rsp_valid_o (bus_rsp_valid_o),
      .bus_rsp_ready_i (bus_rsp_ready_i)
   );

endmodule

// ==== tests/correlator_tb.sv ====
`timescale 1ns/1ps

module correlator_tb;

   logic                   clk_x;
   logic                   rst;
   corr_cfg_pkg::sample_t  sample_i;
   logic                   sample_valid_i;
   logic                   sample_ready_o;
   logic                   swap_i;
   corr_bus_pkg::bus_req_t bus_req_i;
   logic                   bus_req_valid_i;
   logic                   bus_req_ready_o;
   corr_bus_pkg::bus_rsp_t bus_rsp_o;
   logic                   bus_rsp_valid_o;
   logic                   bus_rsp_ready_i;
   logic                   overflow_cos_o;
   logic                   overflow_sin_o;

   logic [31:0] rng_state   = 32'd12551;
   int          checks      = 0;
   int          errors      = 0;
   int          cycle_count = 0;
   int          cycle_limit = 380 * 13 + 136 * 16 + 1000;   // samples, bus transfers, slack

   // reference counts of the period in progress, wrap mod 2^ACC_W
   logic [corr_cfg_pkg::ACC_W-1:0] exp_cos [corr_cfg_pkg::PAIR_COUNT];
   logic [corr_cfg_pkg::ACC_W-1:0] exp_sin [corr_cfg_pkg::PAIR_COUNT];
   logic                           exp_ovf_cos = 1'b0;   // sticky like the DUT flags
   logic                           exp_ovf_sin = 1'b0;

   correlator_top correlator_top_i (.*);

   initial begin
      clk_x = 1'b0;
      forever #4 clk_x = ~clk_x;
   end

   always @(posedge clk_x) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, a handshake never completed", cycle_count);
         $display("** FAIL **");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic draw(output logic [31:0] r);
      rng_state = xorshift32(rng_state);
      r = rng_state;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic model_clear();
      for (int p = 0; p < corr_cfg_pkg::PAIR_COUNT; p++) begin
         exp_cos[p] = '0;
         exp_sin[p] = '0;
      end
   endtask

   // cos hit when both real bits agree, sin hit when a.re agrees with b.im
   task automatic model_add(input corr_cfg_pkg::sample_t s);
      int a;
      int b;
      for (int p = 0; p < corr_cfg_pkg::PAIR_COUNT; p++) begin
         a = corr_cfg_pkg::PAIR_TABLE[p].a;
         b = corr_cfg_pkg::PAIR_TABLE[p].b;
         if (s.re[a] == s.re[b]) begin
            if (exp_cos[p] == '1) exp_ovf_cos = 1'b1;
            exp_cos[p] = exp_cos[p] + 1'b1;
         end
         if (s.re[a] == s.im[b]) begin
            if (exp_sin[p] == '1) exp_ovf_sin = 1'b1;
            exp_sin[p] = exp_sin[p] + 1'b1;
         end
      end
   endtask

   function automatic logic [corr_cfg_pkg::ACC_W-1:0] expected_word(
         input logic [corr_bus_pkg::BUS_ADDR_W-1:0] addr);
      logic [corr_cfg_pkg::PAIR_W-1:0] p;
      p = addr[corr_bus_pkg::BUS_ADDR_W-1:1];
      if (p >= corr_cfg_pkg::PAIR_COUNT) return '0;   // unused pairs read zero
      return addr[0] ? exp_sin[p] : exp_cos[p];
   endfunction

   // ------------------------------------------------------------------------
   // sample side
   // ------------------------------------------------------------------------
   task automatic feed_period(input int n, input logic flat);
      logic [31:0] r_gap;
      logic [31:0] r_re;
      logic [31:0] r_im;
      logic        fire;
      int          sent;
      sent = 0;
      fire = 1'b0;
      while (sent < n) begin
         @(posedge clk_x);
         if (fire) begin
            model_add(sample_i);         // word still holds the accepted value
            sent++;
         end
         if (sent >= n)
            sample_valid_i <= 1'b0;
         else if (!sample_valid_i || fire) begin
            draw(r_gap);
            draw(r_re);
            draw(r_im);
            sample_valid_i <= (r_gap[1:0] != 2'b00);   // idle about one slot in four
            sample_i.re    <= flat ? '1 : r_re[corr_cfg_pkg::ANT_COUNT-1:0];
            sample_i.im    <= flat ? '1 : r_im[corr_cfg_pkg::ANT_COUNT-1:0];
         end
         @(negedge clk_x);
         if (fire)
            check_value("sample_ready_o", sample_ready_o, 1'b0);   // sweep of that word runs
         fire = sample_valid_i && sample_ready_o;
      end
   endtask

   task automatic close_period();
      @(posedge clk_x);
      swap_i <= 1'b1;                  // held pending until pair 11 goes out
      @(posedge clk_x);
      swap_i <= 1'b0;
      @(negedge clk_x);
      while (!sample_ready_o)
         @(negedge clk_x);
      repeat (5) @(posedge clk_x);     // final write plus bank tag settle
   endtask

   task automatic verify_overflow();
      @(negedge clk_x);
      check_value("overflow_cos_o", overflow_cos_o, exp_ovf_cos);
      check_value("overflow_sin_o", overflow_sin_o, exp_ovf_sin);
   endtask

   // ------------------------------------------------------------------------
   // bus side, one transfer at a time
   // ------------------------------------------------------------------------
   task automatic bus_xfer(input corr_bus_pkg::bus_op_e op,
                           input logic [corr_bus_pkg::BUS_ADDR_W-1:0] addr,
                           input logic stall, output logic [corr_cfg_pkg::ACC_W-1:0] rdata);
      logic [31:0]                    r;
      logic                           req_fire;
      logic                           rsp_fire;
      logic                           stalled;    // valid and not taken last cycle
      logic                           wait_rsp;   // request went in at the last edge
      logic [corr_cfg_pkg::ACC_W-1:0] held;
      draw(r);
      @(posedge clk_x);
      bus_req_valid_i <= 1'b1;
      bus_req_i.op    <= op;
      bus_req_i.addr  <= addr;
      bus_req_i.wdata <= r[corr_cfg_pkg::ACC_W-1:0];
      stalled  = 1'b0;
      wait_rsp = 1'b0;
      rsp_fire = 1'b0;
      held     = '0;
      while (!rsp_fire) begin
         @(negedge clk_x);
         if (wait_rsp) check_value("bus_rsp_valid_o", bus_rsp_valid_o, 1'b1);
         if (stalled) check_value("bus_rsp_o.rdata hold", bus_rsp_o.rdata, held);
         if (bus_rsp_valid_o && !bus_rsp_ready_i)
            check_value("bus_req_ready_o", bus_req_ready_o, 1'b0);
         req_fire = bus_req_valid_i && bus_req_ready_o;
         rsp_fire = bus_rsp_valid_o && bus_rsp_ready_i;
         stalled  = bus_rsp_valid_o && !bus_rsp_ready_i;
         held     = bus_rsp_o.rdata;
         @(posedge clk_x);
         wait_rsp = req_fire;
         if (req_fire) bus_req_valid_i <= 1'b0;
         draw(r);
         bus_rsp_ready_i <= stall ? r[0] : 1'b1;   // half the cycles back-pressured
      end
      rdata = held;
   endtask

   task automatic read_bank(input logic stall);
      logic [corr_cfg_pkg::ACC_W-1:0] got;
      for (int a = 0; a < 2 * corr_cfg_pkg::PAIR_COUNT; a++) begin
         bus_xfer(corr_bus_pkg::BUS_READ, 5'(a), stall, got);
         check_value($sformatf("bus_rsp_o.rdata addr 0x%02h", a), got, expected_word(5'(a)));
      end
   endtask

   // every address, in range or not, must ack with zero and keep its contents
   task automatic write_ignored();
      logic [corr_cfg_pkg::ACC_W-1:0] got;
      for (int a = 0; a < 32; a++) begin
         bus_xfer(corr_bus_pkg::BUS_WRITE, 5'(a), 1'b0, got);
         check_value($sformatf("bus_rsp_o.rdata write 0x%02h", a), got, 0);
         bus_xfer(corr_bus_pkg::BUS_READ, 5'(a), 1'b0, got);
         check_value($sformatf("bus_rsp_o.rdata reread 0x%02h", a), got,
                     expected_word(5'(a)));
      end
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin
      rst             = 1'b1;
      sample_i        = '0;
      sample_valid_i  = 1'b0;
      swap_i          = 1'b0;
      bus_req_i       = '0;
      bus_req_valid_i = 1'b0;
      bus_rsp_ready_i = 1'b1;
      model_clear();
      repeat (8) @(posedge clk_x);
      rst <= 1'b0;

      feed_period(40, 1'b0);           // period 1 into bank 0
      close_period();
      verify_overflow();
      read_bank(1'b0);
      write_ignored();

      model_clear();                   // period 2 into bank 1, fresh counts
      feed_period(40, 1'b0);
      close_period();
      verify_overflow();
      read_bank(1'b1);

      model_clear();                   // 300 hits per pair, wraps to 44
      feed_period(300, 1'b1);
      close_period();
      verify_overflow();
      read_bank(1'b1);
      verify_overflow();               // flags must still be set

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== sim.f ====
logic/corr_cfg_pkg.sv
logic/corr_bus_pkg.sv
logic/pair_select.sv
logic/cos_sin_mac.sv
logic/vis_bank.sv
logic/correlator_top.sv
tests/correlator_tb.sv

// ==== Bender.yml ====
package:
  name: correlator

sources:
  - logic/corr_cfg_pkg.sv
  - logic/corr_bus_pkg.sv
  - logic/pair_select.sv
  - logic/cos_sin_mac.sv
  - logic/vis_bank.sv
  - logic/correlator_top.sv
  - target: test
    files:
      - tests/correlator_tb.sv
